//--- test/analogizer_input.txt
# W addr data | R addr read_data | X random_pixel_count
# P ena r g b hsync csync blank_n bank1 bank2 bank3 dir, dir is {pin30,dir3,dir2,dir1}, all hex
R f7000000 00000000
P 0 ff ff ff 1 1 1 00 00 00 0
P 1 ff 80 44 0 0 1 08 e0 fd f
P 1 ff ff ff 1 1 0 00 00 03 f
P 1 0c fc fe 1 1 1 1f ff 0f f
X 10
W f6000000 12340000
R f6000000 00000000
W f7000000 c584abcd
R f7000000 c5840000
P 1 ff 80 44 0 0 1 08 e0 fe f
P 1 40 20 10 0 1 1 02 48 43 f
P 1 ff ff ff 0 0 0 00 00 02 f
P 0 40 20 10 0 1 1 00 00 00 0
X 10
W f7000000 00480000
R f7000000 00480000
P 1 ff ff ff 0 0 1 10 7f 82 f
P 1 ff 00 00 0 1 1 0b d2 db f
P 1 00 00 fc 1 0 1 1e 46 76 f
P 1 00 fc 00 0 1 1 06 e5 37 f
P 1 ff ff ff 1 0 0 10 40 82 f
X 12
W f7000000 1f0c0000
R f7000000 1f0c0000
P 1 ff 80 44 1 0 1 00 40 03 f
P 1 ff 80 44 0 1 0 00 00 01 f
X 8
W f7000000 003c0000
X 6
W f7000000 00000000
X 10
P 0 12 34 56 1 1 1 00 00 00 0

//--- files.f
hdl/analogizer_pkg.sv
hdl/video_if.sv
hdl/analogizer_settings.sv
hdl/ypbpr_encoder.sv
hdl/video_mode_mux.sv
hdl/cart_port_map.sv
hdl/analogizer_top.sv
test/tb_analogizer.sv

//--- run_sim.sh
#!/bin/sh
# Build the analogizer testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 -f files.f --top-module tb_analogizer -o tb_sim || exit 1
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && echo "Simulation FAILED" && exit 1
grep -q "Testbench passed" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"

//--- test/tb_analogizer.sv
/*
 * Analogizer video adapter testbench
 * Replays bridge accesses and pixels from the input file and adds
 * random pixels that are checked against a model of the format rules
 */
`timescale 1ns/10ps

module tb_analogizer;

	localparam logic [7:0] CFG_ADDR   = 8'hF7;
	localparam string      INPUT_FILE = "test/analogizer_input.txt";

	typedef struct packed {
		logic [31:0] due;   // Tick at which the pins must show it
		logic [7:0]  b1;
		logic [7:0]  b2;
		logic [7:0]  b3;
		logic [3:0]  dir;   // pin30, bank3, bank2, bank1
	} pix_exp_t;

	logic        i_clk;
	logic        i_rst_n;
	logic [31:0] i_bridge_addr;
	logic        i_bridge_wr;
	logic [31:0] i_bridge_wr_data;
	logic        i_bridge_rd;
	logic [31:0] o_bridge_rd_data;
	logic [7:0]  i_r, i_g, i_b;
	logic        i_hsync, i_csync, i_blank_n, i_ena;
	logic [4:0]  o_cont_type;
	logic [3:0]  o_cont_assign, o_video_type;
	logic        o_blank_screen, o_osd;
	logic [7:0]  o_bank1, o_bank2, o_bank3;
	logic        o_bank1_dir, o_bank2_dir, o_bank3_dir, o_pin30_pwroff_reset;

	pix_exp_t         exp_q [$];  // Pixels still in the pipeline
	int               tick = 0;
	int               cycle_cnt = 0;
	int               cycle_limit = 0;
	int               n_lines = 0;
	int               fd;
	int               scan_cnt;
	logic [15:0]      exp_cfg = '0; // Settings word as the DUT should hold it
	logic [7:0]       kind;
	logic [8*128-1:0] line_buf;
	logic [31:0]      f_a, f_d, seed_dummy;
	logic [7:0]       f_r, f_g, f_b, f_b1, f_b2, f_b3;
	logic             f_ena, f_hs, f_cs, f_bn;
	logic [3:0]       f_dir;
	int               f_cnt;

	analogizer_top #(.CONFIG_ADDR(CFG_ADDR)) u_analogizer_top (.*);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk; // 25 MHz
	end

	// Cycle budget from the length of the input file
	always @(posedge i_clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("Timeout: run still going after %0d cycles", cycle_cnt);
			$display("Testbench failed");
			$fatal(1, "Run exceeded its cycle budget");
		end
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Testbench failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// Stops on a stimulus line with missing or unreadable fields
	task automatic require_fields(input int got, input int want);
		if (got != want) begin
			$display("Stimulus line has %0d readable fields, %0d were expected", got, want);
			$display("Testbench failed");
			$fatal(1, "Bad stimulus file");
		end
	endtask

	// Floor of x/2, also for negative x
	function automatic int floor_half(input int x);
		if (x >= 0) begin
			return x / 2;
		end else begin
			return -((1 - x) / 2);
		end
	endfunction

	// Bank bytes {bank1, bank2, bank3} for one pixel with the port enabled
	function automatic logic [23:0] model_banks(input logic [3:0] mode, input logic [7:0] r,
			input logic [7:0] g, input logic [7:0] b, input logic hs, input logic cs,
			input logic bn);
		int         rm, gm, bm, y;
		logic [5:0] ro, go, bo;
		logic       hso, vso, bno;
		rm  = bn ? int'(r[7:2]) : 0; // Top 6 bits, zero while blanking
		gm  = bn ? int'(g[7:2]) : 0;
		bm  = bn ? int'(b[7:2]) : 0;
		ro  = 6'(rm);
		go  = 6'(gm);
		bo  = 6'(bm);
		hso = 1'b1;
		vso = 1'b1;
		bno = bn;
		case (mode)
			4'd0: hso = cs;
			4'd1: vso = cs; // Sync on green
			4'd2: begin
				y   = (19 * rm + 38 * gm + 7 * bm) / 64;
				go  = 6'(y);
				bo  = 6'(32 + floor_half(bm - y));
				ro  = 6'(32 + floor_half(rm - y));
				vso = cs;
				bno = 1'b1;
			end
			default: begin
				ro  = '0;
				go  = '0;
				bo  = '0;
				hso = hs;
			end
		endcase
		return {3'b000, bo[5:1], bo[0], bno, go, ro, hso, vso};
	endfunction

	// Advance to the next edge, check any pixel due now, return at the drive point
	task automatic next_cycle();
		pix_exp_t e;
		@(posedge i_clk);
		tick++;
		#1;
		if (exp_q.size() > 0 && exp_q[0].due == tick) begin
			e = exp_q.pop_front();
			check_value(32'(o_bank1), 32'(e.b1), "bank1");
			check_value(32'(o_bank2), 32'(e.b2), "bank2");
			check_value(32'(o_bank3), 32'(e.b3), "bank3");
			check_value(32'({o_pin30_pwroff_reset, o_bank3_dir, o_bank2_dir, o_bank1_dir}),
				32'(e.dir), "pin30 and direction bits");
		end
		#1;
	endtask

	task automatic drain();
		while (exp_q.size() > 0) next_cycle();
	endtask

	task automatic check_settings(input logic [15:0] cfg);
		check_value(32'(o_cont_type), 32'(cfg[4:0]), "cont_type");
		check_value(32'(o_cont_assign), 32'(cfg[9:6]), "cont_assign");
		check_value(32'(o_video_type), 32'(cfg[13:10]), "video_type");
		check_value(32'(o_blank_screen), 32'(cfg[14]), "blank_screen");
		check_value(32'(o_osd), 32'(cfg[15]), "osd");
	endtask

	task automatic drive_pixel(input logic ena, input logic [7:0] r, input logic [7:0] g,
			input logic [7:0] b, input logic hs, input logic cs, input logic bn,
			input logic [23:0] banks, input logic [3:0] dir);
		pix_exp_t e;
		if (ena !== i_ena) drain(); // Gating is combinational, let older pixels out first
		i_ena     = ena;
		i_r       = r;
		i_g       = g;
		i_b       = b;
		i_hsync   = hs;
		i_csync   = cs;
		i_blank_n = bn;
		e.due = tick + 3;
		e.b1  = banks[23:16];
		e.b2  = banks[15:8];
		e.b3  = banks[7:0];
		e.dir = dir;
		exp_q.push_back(e);
		next_cycle();
	endtask

	task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
		drain();
		i_bridge_addr    = addr;
		i_bridge_wr_data = data;
		i_bridge_wr      = 1'b1;
		next_cycle();
		i_bridge_wr = 1'b0;
		check_settings(exp_cfg); // Decode lags by one more cycle
		if (addr == {CFG_ADDR, 24'h000000}) exp_cfg = {data[23:16], data[31:24]};
		next_cycle();
		check_settings(exp_cfg);
	endtask

	task automatic bridge_read(input logic [31:0] addr, input logic [31:0] exp);
		i_bridge_addr = addr;
		i_bridge_rd   = 1'b1;
		next_cycle();
		i_bridge_rd = 1'b0;
		check_value(o_bridge_rd_data, exp, "bridge read data");
		if (addr == {CFG_ADDR, 24'h000000}) begin
			// Same top byte with a low address bit set is unmapped
			i_bridge_addr = {CFG_ADDR, 24'h000004};
			i_bridge_rd   = 1'b1;
			next_cycle();
			i_bridge_rd = 1'b0;
			check_value(o_bridge_rd_data, 32'h0, "bridge read data next to the settings word");
		end
	endtask

	initial begin
		seed_dummy       = $urandom(32'h5d5a);
		i_rst_n          = 1'b0;
		i_ena            = 1'b1; // Reset alone must park the port
		i_bridge_addr    = '0;
		i_bridge_wr      = 1'b0;
		i_bridge_wr_data = '0;
		i_bridge_rd      = 1'b0;
		i_r              = '0;
		i_g              = '0;
		i_b              = '0;
		i_hsync          = 1'b0;
		i_csync          = 1'b0;
		i_blank_n        = 1'b0;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file %s", INPUT_FILE);
			$display("Testbench failed");
			$fatal(1, "No stimulus");
		end
		while ($fgets(line_buf, fd) != 0) n_lines++;
		$fclose(fd);
		cycle_limit = 40 * n_lines + 200;
		fd = $fopen(INPUT_FILE, "r");
		repeat (16) next_cycle();
		check_value(32'({o_bank1, o_bank2, o_bank3}), 32'h0, "banks in reset");
		check_value(32'({o_pin30_pwroff_reset, o_bank3_dir, o_bank2_dir, o_bank1_dir}),
			32'h0, "direction bits in reset");
		i_rst_n = 1'b1;
		i_ena   = 1'b0;
		check_settings(16'h0000);
		while ($fscanf(fd, " %c", kind) == 1) begin
			case (kind)
				"#": scan_cnt = $fgets(line_buf, fd);
				"W": begin
					scan_cnt = $fscanf(fd, "%h %h", f_a, f_d);
					require_fields(scan_cnt, 2);
					bridge_write(f_a, f_d);
				end
				"R": begin
					scan_cnt = $fscanf(fd, "%h %h", f_a, f_d);
					require_fields(scan_cnt, 2);
					bridge_read(f_a, f_d);
				end
				"P": begin
					scan_cnt = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f_ena, f_r,
						f_g, f_b, f_hs, f_cs, f_bn, f_b1, f_b2, f_b3, f_dir);
					require_fields(scan_cnt, 11);
					drive_pixel(f_ena, f_r, f_g, f_b, f_hs, f_cs, f_bn, {f_b1, f_b2, f_b3},
						f_dir);
				end
				"X": begin
					scan_cnt = $fscanf(fd, "%d", f_cnt);
					require_fields(scan_cnt, 1);
					repeat (f_cnt) begin
						f_r  = 8'($urandom);
						f_g  = 8'($urandom);
						f_b  = 8'($urandom);
						f_hs = 1'($urandom);
						f_cs = 1'($urandom);
						f_bn = ($urandom_range(3, 0) != 0); // Mostly active video
						drive_pixel(1'b1, f_r, f_g, f_b, f_hs, f_cs, f_bn,
							model_banks(exp_cfg[13:10], f_r, f_g, f_b, f_hs, f_cs, f_bn), 4'hf);
					end
				end
				default: begin
					$display("Unknown line kind %c in the stimulus file", kind);
					$display("Testbench failed");
					$fatal(1, "Bad stimulus file");
				end
			endcase
		end
		$fclose(fd);
		drain();
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- hdl/analogizer_top.sv
/*
 * Analogizer video adapter top
 * Bridge settings register, analog video formatter and the
 * cartridge pin mapper, all on one clock
 */
`timescale 1ns/10ps

module analogizer_top import analogizer_pkg::*; #(
	parameter logic [7:0] CONFIG_ADDR = DEFAULT_CONFIG_ADDR
) (
	input  logic                i_clk,
	input  logic                i_rst_n,
	// Bridge
	input  logic [31:0]         i_bridge_addr,
	input  logic                i_bridge_wr,
	input  logic [31:0]         i_bridge_wr_data,
	input  logic                i_bridge_rd,
	output logic [31:0]         o_bridge_rd_data,
	// Core video
	input  logic [PIX_IN_W-1:0] i_r,
	input  logic [PIX_IN_W-1:0] i_g,
	input  logic [PIX_IN_W-1:0] i_b,
	input  logic                i_hsync,
	input  logic                i_csync,
	input  logic                i_blank_n,
	input  logic                i_ena,
	// Decoded settings
	output logic [4:0]          o_cont_type,
	output logic [3:0]          o_cont_assign,
	output logic [3:0]          o_video_type,
	output logic                o_blank_screen,
	output logic                o_osd,
	// Cartridge port
	output logic [7:0]          o_bank1,
	output logic [7:0]          o_bank2,
	output logic [7:0]          o_bank3,
	output logic                o_bank1_dir,
	output logic                o_bank2_dir,
	output logic                o_bank3_dir,
	output logic                o_pin30_pwroff_reset
);

	settings_t settings;

	video_if u_vid ();

	analogizer_settings #(
		.CONFIG_ADDR (CONFIG_ADDR)
	) u_analogizer_settings (
		.i_clk            (i_clk),
		.i_rst_n          (i_rst_n),
		.i_bridge_addr    (i_bridge_addr),
		.i_bridge_wr      (i_bridge_wr),
		.i_bridge_wr_data (i_bridge_wr_data),
		.i_bridge_rd      (i_bridge_rd),
		.o_bridge_rd_data (o_bridge_rd_data),
		.o_settings       (settings)
	);

	assign o_cont_type    = settings.cont_type;
	assign o_cont_assign  = settings.cont_assign;
	assign o_video_type   = settings.video_type;
	assign o_blank_screen = settings.blank_screen;
	assign o_osd          = settings.osd;

	video_mode_mux u_video_mode_mux (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_mode    (video_mode_e'(settings.video_type)), // Codes above 2 blank
		.i_r       (i_r),
		.i_g       (i_g),
		.i_b       (i_b),
		.i_hsync   (i_hsync),
		.i_csync   (i_csync),
		.i_blank_n (i_blank_n),
		.o_vid     (u_vid.src)
	);

	cart_port_map u_cart_port_map (
		.i_rst_n              (i_rst_n),
		.i_ena                (i_ena),
		.i_vid                (u_vid.dst),
		.o_bank1              (o_bank1),
		.o_bank2              (o_bank2),
		.o_bank3              (o_bank3),
		.o_bank1_dir          (o_bank1_dir),
		.o_bank2_dir          (o_bank2_dir),
		.o_bank3_dir          (o_bank3_dir),
		.o_pin30_pwroff_reset (o_pin30_pwroff_reset)
	);

endmodule

//--- hdl/cart_port_map.sv
/*
 * Cartridge port mapper
 * Places the formatted sample on the three video bank bytes in the
 * adapter's pin order and parks the port while disabled or in reset
 */
`timescale 1ns/10ps

module cart_port_map import analogizer_pkg::*; (
	input  logic       i_rst_n,
	input  logic       i_ena,
	video_if.dst       i_vid,
	output logic [7:0] o_bank1,
	output logic [7:0] o_bank2,
	output logic [7:0] o_bank3,
	output logic       o_bank1_dir,
	output logic       o_bank2_dir,
	output logic       o_bank3_dir,
	output logic       o_pin30_pwroff_reset
);

	logic       drive;   // Port owned by the adapter
	logic [7:0] bank1_w;
	logic [7:0] bank2_w;
	logic [7:0] bank3_w;

	assign drive = i_rst_n & i_ena;

	// Pins 7..14, R5 lands on bank3[7]
	assign bank3_w = {i_vid.r, i_vid.hsync, i_vid.vsync};

	// B0 and /BLANK sit between the green pins and bank1
	assign bank2_w = {i_vid.b[0], i_vid.blank_n, i_vid.g};

	// Upper bits belong to the SNAC side and the video clock, held low
	assign bank1_w = {3'b000, i_vid.b[PIX_W-1:1]};

	// Idle state is input direction with the byte at zero
	always_comb begin
		if (drive) begin
			o_bank1 = bank1_w;
			o_bank2 = bank2_w;
			o_bank3 = bank3_w;
		end else begin
			o_bank1 = 8'h00;
			o_bank2 = 8'h00;
			o_bank3 = 8'h00;
		end
	end

	assign o_bank1_dir          = drive;
	assign o_bank2_dir          = drive;
	assign o_bank3_dir          = drive;
	assign o_pin30_pwroff_reset = drive; // High for GPIO use

endmodule

//--- hdl/video_mode_mux.sv
/*
 * Analog video formatter
 * Cuts core colour to DAC width, masks it during blanking, and
 * builds the RGBS, RGsB or YPbPr sample with the matching sync lines
 * Fixed latency of three clocks in every mode
 */
`timescale 1ns/10ps

module video_mode_mux import analogizer_pkg::*; (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  video_mode_e         i_mode,
	input  logic [PIX_IN_W-1:0] i_r,
	input  logic [PIX_IN_W-1:0] i_g,
	input  logic [PIX_IN_W-1:0] i_b,
	input  logic                i_hsync,
	input  logic                i_csync,
	input  logic                i_blank_n,
	video_if.src                o_vid
);

	// Side path that waits for the encoder
	typedef struct packed {
		logic [PIX_W-1:0] r;
		logic [PIX_W-1:0] g;
		logic [PIX_W-1:0] b;
		logic             hsync;
		logic             csync;
		logic             blank_n;
	} dly_t;

	dly_t             dly_in;
	dly_t             dly_q [ENC_LATENCY];
	dly_t             dly_out;
	logic [PIX_W-1:0] enc_y;
	logic [PIX_W-1:0] enc_pb;
	logic [PIX_W-1:0] enc_pr;
	logic             enc_csync;

	// Top bits of each channel, zeroed while blanking
	assign dly_in.r       = i_r[PIX_IN_W-1 -: PIX_W] & {PIX_W{i_blank_n}};
	assign dly_in.g       = i_g[PIX_IN_W-1 -: PIX_W] & {PIX_W{i_blank_n}};
	assign dly_in.b       = i_b[PIX_IN_W-1 -: PIX_W] & {PIX_W{i_blank_n}};
	assign dly_in.hsync   = i_hsync;
	assign dly_in.csync   = i_csync;
	assign dly_in.blank_n = i_blank_n;

	ypbpr_encoder u_ypbpr_encoder (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_r     (dly_in.r), // Masked colour
		.i_g     (dly_in.g),
		.i_b     (dly_in.b),
		.i_csync (i_csync),
		.o_y     (enc_y),
		.o_pb    (enc_pb),
		.o_pr    (enc_pr),
		.o_csync (enc_csync)
	);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < ENC_LATENCY; i++) begin
				dly_q[i] <= '0;
			end
		end else begin
			dly_q[0] <= dly_in;
			for (int i = 1; i < ENC_LATENCY; i++) begin
				dly_q[i] <= dly_q[i-1];
			end
		end
	end

	assign dly_out = dly_q[ENC_LATENCY-1];

	// Output register, mode is sampled here
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_vid.r       <= '0;
			o_vid.g       <= '0;
			o_vid.b       <= '0;
			o_vid.hsync   <= 1'b0;
			o_vid.vsync   <= 1'b0;
			o_vid.blank_n <= 1'b0;
		end else begin
			case (i_mode)
				MODE_RGBS: begin
					o_vid.r       <= dly_out.r;
					o_vid.g       <= dly_out.g;
					o_vid.b       <= dly_out.b;
					o_vid.hsync   <= dly_out.csync; // Composite on the hsync pin
					o_vid.vsync   <= 1'b1;
					o_vid.blank_n <= dly_out.blank_n;
				end
				MODE_RGSB: begin
					o_vid.r       <= dly_out.r;
					o_vid.g       <= dly_out.g;
					o_vid.b       <= dly_out.b;
					o_vid.hsync   <= 1'b1;
					o_vid.vsync   <= dly_out.csync; // To DAC sync, SOG switch on
					o_vid.blank_n <= dly_out.blank_n;
				end
				MODE_YPBPR: begin
					o_vid.r       <= enc_pr;
					o_vid.g       <= enc_y;
					o_vid.b       <= enc_pb;
					o_vid.hsync   <= 1'b1;
					o_vid.vsync   <= enc_csync;
					o_vid.blank_n <= 1'b1; // DAC blank would cut the sync tip
				end
				default: begin
					// Output disabled, keep hsync for the monitor
					o_vid.r       <= '0;
					o_vid.g       <= '0;
					o_vid.b       <= '0;
					o_vid.hsync   <= dly_out.hsync;
					o_vid.vsync   <= 1'b1;
					o_vid.blank_n <= dly_out.blank_n;
				end
			endcase
		end
	end

endmodule

//--- hdl/ypbpr_encoder.sv
/*
 * RGB to YPbPr encoder
 * Two-stage colour matrix on 6-bit channels
 * Y = (19R + 38G + 7B) / 64, Pb and Pr are half the colour
 * differences around mid scale, csync rides along the pipeline
 */
`timescale 1ns/10ps

module ypbpr_encoder import analogizer_pkg::*; (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic [PIX_W-1:0] i_r,
	input  logic [PIX_W-1:0] i_g,
	input  logic [PIX_W-1:0] i_b,
	input  logic             i_csync,
	output logic [PIX_W-1:0] o_y,
	output logic [PIX_W-1:0] o_pb,
	output logic [PIX_W-1:0] o_pr,
	output logic             o_csync
);

	localparam int SUM_W = PIX_W + 6; // Weights add up to 64

	logic [SUM_W-1:0] y_sum_w;
	logic [SUM_W-1:0] y_sum_q;
	logic [PIX_W-1:0] r_q;
	logic [PIX_W-1:0] b_q;
	logic             cs_q;
	logic [PIX_W-1:0] y_w;
	logic signed [PIX_W:0] db_w; // B - Y, -63..63
	logic signed [PIX_W:0] dr_w; // R - Y
	logic signed [PIX_W:0] pb_w;
	logic signed [PIX_W:0] pr_w;

	// Weighted luma sum, max 63 * 64 fits in SUM_W
	assign y_sum_w = SUM_W'(19) * {6'd0, i_r}
	               + SUM_W'(38) * {6'd0, i_g}
	               + SUM_W'(7)  * {6'd0, i_b};

	// Stage one
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			y_sum_q <= '0;
			r_q     <= '0;
			b_q     <= '0;
			cs_q    <= 1'b0;
		end else begin
			y_sum_q <= y_sum_w;
			r_q     <= i_r;     // G is only needed for luma
			b_q     <= i_b;
			cs_q    <= i_csync;
		end
	end

	// Divide by 64 is a plain shift, floor
	assign y_w = y_sum_q[SUM_W-1 -: PIX_W];

	// Arithmetic shift rounds toward minus infinity, as floor division does
	assign db_w = $signed({1'b0, b_q}) - $signed({1'b0, y_w});
	assign dr_w = $signed({1'b0, r_q}) - $signed({1'b0, y_w});
	assign pb_w = (PIX_W+1)'(32) + (db_w >>> 1); // Stays within 0..63
	assign pr_w = (PIX_W+1)'(32) + (dr_w >>> 1);

	// Stage two
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_y     <= '0;
			o_pb    <= '0;
			o_pr    <= '0;
			o_csync <= 1'b0;
		end else begin
			o_y     <= y_w;
			o_pb    <= pb_w[PIX_W-1:0];
			o_pr    <= pr_w[PIX_W-1:0];
			o_csync <= cs_q;
		end
	end

endmodule

//--- hdl/analogizer_settings.sv
/*
 * Analogizer settings register
 * Captures the settings word from a bridge write to one address,
 * returns it on a bridge read and presents the decoded record
 */
`timescale 1ns/10ps

module analogizer_settings import analogizer_pkg::*; #(
	parameter logic [7:0] CONFIG_ADDR = DEFAULT_CONFIG_ADDR
) (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic [31:0] i_bridge_addr,
	input  logic        i_bridge_wr,
	input  logic [31:0] i_bridge_wr_data,
	input  logic        i_bridge_rd,
	output logic [31:0] o_bridge_rd_data,
	output settings_t   o_settings
);

	settings_t cfg_q;   // Stored word
	logic      addr_hit;
	logic      wr_hit;
	logic      rd_hit;

	// Only the top byte selects, the rest must be zero
	assign addr_hit = (i_bridge_addr == {CONFIG_ADDR, 24'h000000});
	assign wr_hit   = i_bridge_wr & addr_hit;
	assign rd_hit   = i_bridge_rd & addr_hit;

	// Settings word, written in swapped byte order
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			cfg_q <= '0;
		end else if (wr_hit) begin
			cfg_q <= cfg_from_wr(i_bridge_wr_data);
		end
	end

	// Read data lands one cycle after the strobe
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_bridge_rd_data <= '0;
		end else if (i_bridge_rd) begin
			if (rd_hit) begin
				o_bridge_rd_data <= cfg_to_rd(cfg_q);
			end else begin
				o_bridge_rd_data <= '0; // Unmapped address
			end
		end
	end

	// Decoded fields, one more stage so they settle two cycles after a write
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_settings <= '0; // Video type reads RGBS
		end else begin
			o_settings.cont_type    <= cfg_q.cont_type;
			o_settings.spare        <= cfg_q.spare;
			o_settings.cont_assign  <= cfg_q.cont_assign;
			o_settings.video_type   <= cfg_q.video_type;
			o_settings.blank_screen <= cfg_q.blank_screen;
			o_settings.osd          <= cfg_q.osd;
		end
	end

endmodule

//--- hdl/video_if.sv
/*
 * Formatted video sample
 * One 6-bit RGB sample with its sync and blank lines, new every clock
 */
`timescale 1ns/10ps

interface video_if import analogizer_pkg::*; ();

	logic [PIX_W-1:0] r;       // Also Pr in YPbPr mode
	logic [PIX_W-1:0] g;       // Also Y
	logic [PIX_W-1:0] b;       // Also Pb
	logic             hsync;   // DAC hsync pin
	logic             vsync;   // DAC sync pin, carries csync in SOG modes
	logic             blank_n;

	// Formatter side
	modport src (output r, g, b, hsync, vsync, blank_n);

	// Pin mapper side
	modport dst (input r, g, b, hsync, vsync, blank_n);

endinterface

//--- hdl/analogizer_pkg.sv
/*
 * Analogizer shared definitions
 * Channel widths, video mode codes, the settings word layout and
 * helpers that convert between the bridge byte order and the record
 */
package analogizer_pkg;

	localparam int PIX_IN_W = 8; // Core colour channel
	localparam int PIX_W    = 6; // Adapter DAC channel

	localparam int ENC_LATENCY = 2; // YPbPr encoder pipeline depth

	localparam logic [7:0] DEFAULT_CONFIG_ADDR = 8'hF7; // Bridge address byte

	// Video output types, anything above YPbPr disables the colour
	typedef enum logic [3:0] {
		MODE_RGBS  = 4'd0,
		MODE_RGSB  = 4'd1, // Sync on green through the SOG switch
		MODE_YPBPR = 4'd2
	} video_mode_e;

	// Settings word, bit 15 first
	typedef struct packed {
		logic       osd;
		logic       blank_screen;
		logic [3:0] video_type;
		logic [3:0] cont_assign;
		logic       spare;      // Adapter enable in older cores, ignored
		logic [4:0] cont_type;  // 16 and above select conf. B
	} settings_t;

	// Bridge data arrives big endian, byte 2 is the upper half of the word
	function automatic settings_t cfg_from_wr(input logic [31:0] wr_data);
		return settings_t'({wr_data[23:16], wr_data[31:24]});
	endfunction

	// Readback swaps the bytes back into bridge order
	function automatic logic [31:0] cfg_to_rd(input settings_t cfg);
		logic [15:0] raw;
		raw = cfg;
		return {raw[7:0], raw[15:8], 16'h0000};
	endfunction

endpackage
